/* files.f */
+incdir+logic
logic/dma_pkg.sv
logic/link_start_seq.sv
logic/rx_desc_dec.sv
logic/rd_chan.sv
logic/np_tx_arb.sv
logic/dma_rd_top.sv
verification/dma_rd_tb.sv

/* logic/dma_cfg.svh */
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// read channel array
`define DMA_CH_NUM      4
`define DMA_CH_W        2

// per channel descriptor queue
`define DMA_Q_DEPTH     4
`define DMA_Q_AW        2
`define DMA_SEQ_W       3

// transaction layer start delay in cfg_clk cycles
`define DMA_START_DLY   16
`define DMA_START_CW    5

// control region decode
`define DMA_CTRL_BAR    1
`define DMA_DESC_OFS    0

// dword length field of a read request
`define DMA_LEN_W       10

`endif

/* logic/dma_pkg.sv */
`default_nettype none

`include "dma_cfg.svh"

package dma_pkg;

    // TLP kinds seen on the simplified RX/TX ports
    typedef enum logic [1:0] {
        OP_MRD  = 2'd0,
        OP_MWR  = 2'd1,
        OP_CPL  = 2'd2,
        OP_CPLD = 2'd3
    } tlp_op_e;

    typedef enum logic [1:0] {
        ST_HOLD  = 2'd0,
        ST_COUNT = 2'd1,
        ST_RUN   = 2'd2
    } start_state_e;

    // reg_addr: [7:6] zero, [5:4] channel, [3:0] register offset
    // data: host address in [63:32], dword length in [9:0]
    typedef struct packed {
        tlp_op_e     op;
        logic [2:0]  bar;
        logic [7:0]  reg_addr;
        logic [63:0] data;
    } rx_tlp_t;

    typedef struct packed {
        logic [31:0]            host_addr;
        logic [`DMA_LEN_W-1:0]  len;
    } rd_desc_t;

    // memory read request header towards the controller
    typedef struct packed {
        tlp_op_e                op;
        logic [15:0]            req_id;
        logic [7:0]             tag;
        logic [31:0]            host_addr;
        logic [`DMA_LEN_W-1:0]  len;
    } tx_tlp_t;

endpackage

`default_nettype wire

/* logic/dma_rd_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_cfg.svh"

module dma_rd_top (
    input  wire                     cfg_clk,
    input  wire                     rstn,
    input  wire                     rx_vld_i,
    input  wire dma_pkg::rx_tlp_t   rx_tlp_i,
    input  wire [15:0]              cfg_busdev_i,
    input  wire                     tx_halt_i,
    output logic                    tx_vld_o,
    output dma_pkg::tx_tlp_t        tx_tlp_o,
    output logic                    link_start_o
);

    logic                     start;
    logic [`DMA_CH_NUM-1:0]   desc_vld;
    dma_pkg::rd_desc_t        desc;
    logic [`DMA_CH_NUM-1:0]   req;
    logic [`DMA_CH_NUM-1:0]   grant;
    dma_pkg::tx_tlp_t         head [`DMA_CH_NUM];

    link_start_seq u_link_start_seq (
        .cfg_clk    (cfg_clk),
        .rstn       (rstn),
        .start_o    (start)
    );

    assign link_start_o = start;

    rx_desc_dec u_rx_desc_dec (
        .cfg_clk    (cfg_clk),
        .rstn       (rstn),
        .start_i    (start),
        .rx_vld_i   (rx_vld_i),
        .rx_tlp_i   (rx_tlp_i),
        .desc_vld_o (desc_vld),
        .desc_o     (desc)
    );

    // one read queue per channel, all sharing the decoded descriptor bus
    for (genvar i = 0; i < `DMA_CH_NUM; i++) begin : g_rd_chan
        rd_chan #(
            .CHAN_IDX   (i)
        ) u_rd_chan (
            .cfg_clk    (cfg_clk),
            .rstn       (rstn),
            .push_i     (desc_vld[i]),
            .desc_i     (desc),
            .req_id_i   (cfg_busdev_i),
            .grant_i    (grant[i]),
            .req_o      (req[i]),
            .head_o     (head[i])
        );
    end

    np_tx_arb u_np_tx_arb (
        .cfg_clk    (cfg_clk),
        .rstn       (rstn),
        .halt_i     (tx_halt_i),
        .req_i      (req),
        .head_i     (head),
        .grant_o    (grant),
        .tx_vld_o   (tx_vld_o),
        .tx_tlp_o   (tx_tlp_o)
    );

endmodule

`default_nettype wire

/* logic/link_start_seq.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_cfg.svh"

module link_start_seq (
    input  wire  cfg_clk,
    input  wire  rstn,
    output logic start_o
);
    import dma_pkg::*;

    start_state_e              state_q;
    logic [`DMA_START_CW-1:0]  dly_cnt_q;

    // first edge out of reset leaves HOLD, counter then runs up to the delay
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            state_q   <= ST_HOLD;
            dly_cnt_q <= '0;
        end else begin
            case (state_q)
                ST_HOLD: begin
                    state_q   <= ST_COUNT;
                    dly_cnt_q <= `DMA_START_CW'(1);
                end
                ST_COUNT: begin
                    if (dly_cnt_q == `DMA_START_CW'(`DMA_START_DLY)) begin
                        state_q <= ST_RUN;
                    end else begin
                        dly_cnt_q <= dly_cnt_q + `DMA_START_CW'(1);
                    end
                end
                ST_RUN:  state_q <= ST_RUN;
                default: state_q <= ST_HOLD;
            endcase
        end
    end

    // transaction logic released only once running
    assign start_o = (state_q == ST_RUN);

endmodule

`default_nettype wire

/* logic/np_tx_arb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_cfg.svh"

module np_tx_arb (
    input  wire                     cfg_clk,
    input  wire                     rstn,
    input  wire                     halt_i,
    input  wire [`DMA_CH_NUM-1:0]   req_i,
    input  wire dma_pkg::tx_tlp_t   head_i [`DMA_CH_NUM],
    output logic [`DMA_CH_NUM-1:0]  grant_o,
    output logic                    tx_vld_o,
    output dma_pkg::tx_tlp_t        tx_tlp_o
);
    import dma_pkg::*;

    logic [`DMA_CH_W-1:0]  last_q;
    logic [`DMA_CH_W-1:0]  cand;
    logic [`DMA_CH_W-1:0]  gnt_idx;
    logic                  gnt_found;
    logic                  gnt_vld;
    tx_tlp_t               gnt_head;

    // ******************************************************************
    // round robin search
    // ******************************************************************

    // start looking one past the channel served last
    always_comb begin
        gnt_found = 1'b0;
        gnt_idx   = last_q;
        cand      = last_q;
        for (int off = 1; off <= `DMA_CH_NUM; off++) begin
            cand = `DMA_CH_W'((last_q + off) % `DMA_CH_NUM);
            if (!gnt_found && req_i[cand]) begin
                gnt_found = 1'b1;
                gnt_idx   = cand;
            end
        end
    end

    // non-posted credit halt blocks any new grant
    assign gnt_vld  = gnt_found && !halt_i;
    assign grant_o  = gnt_vld ? (`DMA_CH_NUM'(1) << gnt_idx) : '0;
    assign gnt_head = head_i[gnt_idx];

    // ******************************************************************
    // pointer and TX register
    // ******************************************************************

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            // so that channel 0 is searched first
            last_q   <= `DMA_CH_W'(`DMA_CH_NUM - 1);
            tx_vld_o <= 1'b0;
        end else begin
            tx_vld_o <= gnt_vld;
            if (gnt_vld) begin
                last_q <= gnt_idx;
            end
        end
    end

    always_ff @(posedge cfg_clk) begin
        if (gnt_vld) begin
            tx_tlp_o <= gnt_head;
        end
    end

endmodule

`default_nettype wire

/* logic/rd_chan.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_cfg.svh"

module rd_chan #(
    parameter int CHAN_IDX = 0
) (
    input  wire                     cfg_clk,
    input  wire                     rstn,
    input  wire                     push_i,
    input  wire dma_pkg::rd_desc_t  desc_i,
    input  wire [15:0]              req_id_i,
    input  wire                     grant_i,
    output logic                    req_o,
    output dma_pkg::tx_tlp_t        head_o
);
    import dma_pkg::*;

    // zero bits above channel index and sequence in the 8-bit tag
    localparam int TAG_PAD = 8 - `DMA_CH_W - `DMA_SEQ_W;
    localparam logic [`DMA_Q_AW:0] Q_FULL = `DMA_Q_DEPTH;

    rd_desc_t               desc_mem [`DMA_Q_DEPTH];
    logic [`DMA_SEQ_W-1:0]  seq_mem  [`DMA_Q_DEPTH];

    logic [`DMA_Q_AW-1:0]   wr_ptr_q;
    logic [`DMA_Q_AW-1:0]   rd_ptr_q;
    logic [`DMA_Q_AW:0]     count_q;
    logic [`DMA_SEQ_W-1:0]  seq_q;

    logic                   full;
    logic                   push_ok;
    logic                   pop;

    assign full    = (count_q == Q_FULL);
    // a descriptor for a full queue is simply lost
    assign push_ok = push_i && !full;
    assign pop     = grant_i && req_o;

    // ******************************************************************
    // queue control
    // ******************************************************************

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            seq_q    <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
                // sequence wraps on its own width
                seq_q    <= seq_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // entry storage, tag sequence captured at push time
    always_ff @(posedge cfg_clk) begin
        if (push_ok) begin
            desc_mem[wr_ptr_q] <= desc_i;
            seq_mem[wr_ptr_q]  <= seq_q;
        end
    end

    // ******************************************************************
    // request and head header
    // ******************************************************************

    assign req_o = (count_q != '0);

    assign head_o.op        = OP_MRD;
    assign head_o.req_id    = req_id_i;
    assign head_o.tag       = {{TAG_PAD{1'b0}}, `DMA_CH_W'(CHAN_IDX), seq_mem[rd_ptr_q]};
    assign head_o.host_addr = desc_mem[rd_ptr_q].host_addr;
    assign head_o.len       = desc_mem[rd_ptr_q].len;

endmodule

`default_nettype wire

/* logic/rx_desc_dec.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_cfg.svh"

module rx_desc_dec (
    input  wire                     cfg_clk,
    input  wire                     rstn,
    input  wire                     start_i,
    input  wire                     rx_vld_i,
    input  wire dma_pkg::rx_tlp_t   rx_tlp_i,
    output logic [`DMA_CH_NUM-1:0]  desc_vld_o,
    output dma_pkg::rd_desc_t       desc_o
);
    import dma_pkg::*;

    logic                  op_hit;
    logic                  bar_hit;
    logic                  addr_hit;
    logic                  len_ok;
    logic                  accept;
    logic [`DMA_CH_W-1:0]  ch_sel;

    // ******************************************************************
    // accept rule
    // ******************************************************************

    assign op_hit  = (rx_tlp_i.op == OP_MWR);
    assign bar_hit = (rx_tlp_i.bar == 3'(`DMA_CTRL_BAR));

    // top bits outside the channel windows, low nibble is the register
    assign addr_hit = (rx_tlp_i.reg_addr[7:6] == 2'b00) &&
                      (rx_tlp_i.reg_addr[3:0] == 4'(`DMA_DESC_OFS));

    // zero length reads are meaningless
    assign len_ok = |rx_tlp_i.data[`DMA_LEN_W-1:0];

    assign accept = start_i && rx_vld_i && op_hit && bar_hit && addr_hit && len_ok;

    assign ch_sel = rx_tlp_i.reg_addr[4 +: `DMA_CH_W];

    // ******************************************************************
    // registered descriptor strobe
    // ******************************************************************

    // one-hot push towards the addressed channel
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            desc_vld_o <= '0;
        end else if (accept) begin
            desc_vld_o <= `DMA_CH_NUM'(1) << ch_sel;
        end else begin
            desc_vld_o <= '0;
        end
    end

    // payload only moves with an accepted write
    always_ff @(posedge cfg_clk) begin
        if (accept) begin
            desc_o.host_addr <= rx_tlp_i.data[63:32];
            desc_o.len       <= rx_tlp_i.data[`DMA_LEN_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* verification/dma_rd_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dma_cfg.svh"

module dma_rd_tb;
    import dma_pkg::*;

    localparam logic [15:0] REQ_ID = 16'h3a08;

    logic        cfg_clk;
    logic        rstn;
    logic        rx_vld_i;
    rx_tlp_t     rx_tlp_i;
    logic [15:0] cfg_busdev_i;
    logic        tx_halt_i;
    logic        tx_vld_o;
    tx_tlp_t     tx_tlp_o;
    logic        link_start_o;

    logic [31:0] lfsr_q;
    tx_tlp_t     exp_q [$];
    int          push_cnt [`DMA_CH_NUM];
    int          tx_count;
    int          err_cnt;
    int          chk_cnt;
    int          test_cnt;
    int          test_err0;
    string       cur_test;
    logic        start_up;
    int          mon_idx;
    logic [1:0]  mon_ch;

    dma_rd_top u_dma_rd_top (
        .cfg_clk      (cfg_clk),
        .rstn         (rstn),
        .rx_vld_i     (rx_vld_i),
        .rx_tlp_i     (rx_tlp_i),
        .cfg_busdev_i (cfg_busdev_i),
        .tx_halt_i    (tx_halt_i),
        .tx_vld_o     (tx_vld_o),
        .tx_tlp_o     (tx_tlp_o),
        .link_start_o (link_start_o)
    );

    initial begin
        cfg_clk = 1'b0;
        forever #50 cfg_clk = ~cfg_clk;
    end

    // **********************************************************************
    // stimulus helpers and reference model
    // **********************************************************************

    // right shifting Galois form, x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return r;
    endfunction

    function automatic logic desc_accepted(input rx_tlp_t t);
        return start_up && (t.op == OP_MWR) && (t.bar == 3'(`DMA_CTRL_BAR)) &&
               (t.reg_addr[7:6] == 2'b00) && (t.reg_addr[3:0] == 4'(`DMA_DESC_OFS)) &&
               (t.data[`DMA_LEN_W-1:0] != '0);
    endfunction

    // expected read header for a write, given the pushes its channel already took
    function automatic tx_tlp_t predict_tx(input rx_tlp_t t, input int cnt,
                                           input logic [15:0] busdev, output logic ok);
        tx_tlp_t r;
        ok          = desc_accepted(t);
        r.op        = OP_MRD;
        r.req_id    = busdev;
        r.tag       = {3'b000, t.reg_addr[5:4], 3'(cnt)};
        r.host_addr = t.data[63:32];
        r.len       = t.data[`DMA_LEN_W-1:0];
        return r;
    endfunction

    function automatic int pending_for(input int ch);
        int n;
        n = 0;
        foreach (exp_q[i]) begin
            if (exp_q[i].tag[4:3] == 2'(ch)) n++;
        end
        return n;
    endfunction

    task automatic check_val(input string name, input logic [127:0] exp_v,
                             input logic [127:0] act_v);
        chk_cnt++;
        if (exp_v !== act_v) begin
            err_cnt++;
            $display("FAILED %s expected %0h actual %0h", name, exp_v, act_v);
        end
    endtask

    task automatic abort_run(input string what);
        $display("error: timed out waiting for %s in test %s", what, cur_test);
        $display("Simulation failed");
        $finish;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_err0 = err_cnt;
    endtask

    task automatic end_test();
        test_cnt++;
        $display("test %s done with %0d errors", cur_test, err_cnt - test_err0);
    endtask

    task automatic send_rx(input tlp_op_e op, input logic [2:0] bar, input logic [7:0] ra,
                           input logic [31:0] addr, input logic [`DMA_LEN_W-1:0] len);
        rx_tlp_t t;
        tx_tlp_t e;
        logic    ok;
        int      ch;
        t.op       = op;
        t.bar      = bar;
        t.reg_addr = ra;
        t.data     = {addr, 22'd0, len};
        ch         = ra[5:4];
        e          = predict_tx(t, push_cnt[ch], cfg_busdev_i, ok);
        // full queue drops the write
        if (ok && pending_for(ch) < `DMA_Q_DEPTH) begin
            exp_q.push_back(e);
            push_cnt[ch]++;
        end
        @(posedge cfg_clk);
        rx_vld_i <= 1'b1;
        rx_tlp_i <= t;
        @(posedge cfg_clk);
        rx_vld_i <= 1'b0;
    endtask

    // cycles counted from the edge that raised the RX strobe
    task automatic wait_tx(output int cyc);
        cyc = 1;
        @(negedge cfg_clk);
        while (tx_vld_o !== 1'b1) begin
            @(posedge cfg_clk);
            cyc++;
            if (cyc > 50) abort_run("a TX strobe");
            @(negedge cfg_clk);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            @(posedge cfg_clk);
            n++;
            if (n > 400) abort_run("outstanding TX headers");
        end
        repeat (4) @(posedge cfg_clk);
    endtask

    // **********************************************************************
    // TX monitor, in order per channel
    // **********************************************************************

    always @(negedge cfg_clk) begin
        if (rstn && tx_vld_o === 1'b1) begin
            tx_count++;
            mon_ch  = tx_tlp_o.tag[4:3];
            mon_idx = -1;
            for (int i = 0; i < exp_q.size(); i++) begin
                if (mon_idx < 0 && exp_q[i].tag[4:3] == mon_ch) mon_idx = i;
            end
            if (mon_idx < 0) begin
                err_cnt++;
                $display("error: TX header with tag %0h arrived when none was expected",
                         tx_tlp_o.tag);
            end else begin
                check_val(cur_test, exp_q[mon_idx], tx_tlp_o);
                exp_q.delete(mon_idx);
            end
        end
    end

    initial begin
        int         lat;
        int         base;
        int         n;
        logic [1:0] ch;
        logic [`DMA_LEN_W-1:0] len;
        rstn         = 1'b0;
        rx_vld_i     = 1'b0;
        rx_tlp_i     = '0;
        cfg_busdev_i = REQ_ID;
        tx_halt_i    = 1'b0;
        lfsr_q       = 32'h458;
        tx_count     = 0;
        err_cnt      = 0;
        chk_cnt      = 0;
        test_cnt     = 0;
        start_up     = 1'b0;
        foreach (push_cnt[i]) push_cnt[i] = 0;

        begin_test("reset");
        @(posedge cfg_clk);
        @(negedge cfg_clk);
        check_val("reset", 2'b00, {link_start_o, tx_vld_o});
        end_test();
        @(posedge cfg_clk);
        rstn <= 1'b1;

        // start delay, with an early descriptor that must be ignored
        begin_test("start_delay");
        @(posedge cfg_clk);
        n = 0;
        @(negedge cfg_clk);
        while (link_start_o !== 1'b1) begin
            @(posedge cfg_clk);
            n++;
            rx_vld_i <= (n == 4);
            rx_tlp_i <= '{op: OP_MWR, bar: 3'(`DMA_CTRL_BAR), reg_addr: 8'h00,
                          data: {32'h1000_0040, 32'd8}};
            if (n > 100) abort_run("link start");
            @(negedge cfg_clk);
        end
        check_val("start_delay", `DMA_START_DLY, n);
        start_up = 1'b1;
        repeat (8) @(posedge cfg_clk);
        check_val("start_early_desc", 0, tx_count);
        end_test();

        begin_test("single");
        for (int c = 0; c < `DMA_CH_NUM; c++) begin
            send_rx(OP_MWR, 3'(`DMA_CTRL_BAR), {2'b00, 2'(c), 4'h0},
                    32'h2000_0000 + 32'(c << 8), 10'(c + 1));
            wait_tx(lat);
            check_val("single latency", 3, lat);
        end
        wait_drain();
        check_val("single count", `DMA_CH_NUM, tx_count);
        end_test();

        begin_test("filter");
        base = tx_count;
        send_rx(OP_MWR, 3'd0, 8'h10, 32'h3000_0000, 10'd4);
        send_rx(OP_MRD, 3'(`DMA_CTRL_BAR), 8'h10, 32'h3000_0100, 10'd4);
        send_rx(OP_MWR, 3'(`DMA_CTRL_BAR), 8'h14, 32'h3000_0200, 10'd4);
        send_rx(OP_MWR, 3'(`DMA_CTRL_BAR), 8'h50, 32'h3000_0300, 10'd4);
        send_rx(OP_MWR, 3'(`DMA_CTRL_BAR), 8'h10, 32'h3000_0400, 10'd0);
        // tag sequence of channel 1 must not have moved
        send_rx(OP_MWR, 3'(`DMA_CTRL_BAR), 8'h10, 32'h3000_0500, 10'd16);
        wait_drain();
        check_val("filter count", 1, tx_count - base);
        end_test();

        begin_test("random");
        base = tx_count;
        for (int i = 0; i < 24; i++) begin
            ch  = rand_bits(2);
            len = rand_bits(`DMA_LEN_W);
            if (len == '0) len = 1;
            send_rx(OP_MWR, 3'(`DMA_CTRL_BAR), {2'b00, ch, 4'h0}, rand_bits(32), len);
            repeat (rand_bits(2)) @(posedge cfg_clk);
        end
        wait_drain();
        check_val("random count", 24, tx_count - base);
        end_test();

        begin_test("halt_overflow");
        base = tx_count;
        @(posedge cfg_clk);
        tx_halt_i <= 1'b1;
        for (int i = 0; i < `DMA_Q_DEPTH + 2; i++) begin
            send_rx(OP_MWR, 3'(`DMA_CTRL_BAR), 8'h20, rand_bits(32), 10'(i + 2));
        end
        repeat (6) @(posedge cfg_clk);
        check_val("halt hold", 0, tx_count - base);
        tx_halt_i <= 1'b0;
        wait_drain();
        check_val("halt count", `DMA_Q_DEPTH, tx_count - base);
        // next tag follows the last accepted push, not the dropped ones
        send_rx(OP_MWR, 3'(`DMA_CTRL_BAR), 8'h20, rand_bits(32), 10'd9);
        wait_drain();
        check_val("halt seq after drop", `DMA_Q_DEPTH + 1, tx_count - base);
        end_test();

        $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
